/* l1_consts.svh */
//==========================================================
// L1 data cache geometry
// address, data, set, way and tag widths
//==========================================================
`ifndef L1_CONSTS_SVH
`define L1_CONSTS_SVH

// byte address and one word per line
`define L1_ADDR_WID   32
`define L1_DATA_WID   32
`define L1_OFFSET_WID 2

// 16 sets of 2 ways
`define L1_SETS       16
`define L1_INDEX_WID  4
`define L1_WAYS       2
`define L1_WAY_WID    1

// tag is what is left above index and offset
`define L1_TAG_WID    26

`endif

/* mesi_pkg.sv */
//==========================================================
// MESI coherence types: line states and snoop operations
//==========================================================
`default_nettype none

package mesi_pkg;

    typedef enum logic [1:0] {
        INVALID   = 2'b00,
        SHARED    = 2'b01,
        EXCLUSIVE = 2'b10,
        MODIFIED  = 2'b11
    } mesi_e;

    // operations seen on the snoop port
    typedef enum logic [1:0] {
        SNP_NONE   = 2'b00,
        SNP_READ   = 2'b01,
        SNP_READ_X = 2'b10,
        SNP_INV    = 2'b11
    } snoop_op_e;

endpackage

`default_nettype wire

/* l1_pkg.sv */
//==========================================================
// L1 cache access types
// CPU and memory ports, controller state, store writes
//==========================================================
`default_nettype none
`include "l1_consts.svh"

package l1_pkg;
    import mesi_pkg::*;

    typedef struct packed {
        logic                    rd;
        logic                    wr;
        logic [`L1_ADDR_WID-1:0] addr;
        logic [`L1_DATA_WID-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                    done;
        logic [`L1_DATA_WID-1:0] rdata;
    } cpu_rsp_t;

    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_READ,
        MEM_READ_X,
        MEM_WRITE,
        MEM_UPGRADE
    } mem_op_e;

    typedef struct packed {
        mem_op_e                 op;
        logic [`L1_ADDR_WID-1:0] addr;
        logic [`L1_DATA_WID-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                    done;
        logic                    shared;
        logic [`L1_DATA_WID-1:0] rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        UPGRADE,
        WRITEBACK,
        FILL,
        RESPOND
    } proc_state_e;

    // proc side writes tag and state together
    typedef struct packed {
        logic                     en;
        logic [`L1_INDEX_WID-1:0] index;
        logic [`L1_WAY_WID-1:0]   way;
        logic [`L1_TAG_WID-1:0]   tag;
        mesi_e                    state;
    } tag_wr_t;

    // snoop side only changes state
    typedef struct packed {
        logic                     en;
        logic [`L1_INDEX_WID-1:0] index;
        logic [`L1_WAY_WID-1:0]   way;
        mesi_e                    state;
    } state_wr_t;

endpackage

`default_nettype wire

/* l1_tag_store.sv */
//==========================================================
// L1 tag and MESI store
// proc and snoop lookup, victim choice, two write ports
//==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "l1_consts.svh"

module l1_tag_store
    import mesi_pkg::*, l1_pkg::*;
(
    input  wire                           clk,
    input  wire                           rst,
    input  wire [`L1_INDEX_WID-1:0]       proc_index,
    input  wire [`L1_TAG_WID-1:0]         proc_tag,
    output logic                          proc_hit,
    output logic [`L1_WAY_WID-1:0]        proc_way,
    output mesi_e                         proc_state,
    output logic [`L1_WAY_WID-1:0]        victim_way,
    output mesi_e                         victim_state,
    output logic [`L1_TAG_WID-1:0]        victim_tag,
    input  wire [`L1_INDEX_WID-1:0]       snoop_index,
    input  wire [`L1_TAG_WID-1:0]         snoop_tag,
    output logic                          snoop_hit,
    output logic [`L1_WAY_WID-1:0]        snoop_way,
    output mesi_e                         snoop_state,
    input  wire tag_wr_t                  proc_wr,
    input  wire state_wr_t                snoop_wr
);

    logic [`L1_TAG_WID-1:0] tag_q   [`L1_SETS][`L1_WAYS];
    mesi_e                  state_q [`L1_SETS][`L1_WAYS];
    logic [`L1_WAY_WID-1:0] rr_q    [`L1_SETS];
    logic                   wr_set_full;
    logic                   wr_new_tag;

    function automatic void lookup(
        input  logic [`L1_INDEX_WID-1:0] idx,
        input  logic [`L1_TAG_WID-1:0]   tag,
        output logic                     hit,
        output logic [`L1_WAY_WID-1:0]   way,
        output mesi_e                    st
    );
        hit = 1'b0;
        way = '0;
        st  = INVALID;
        for (int w = 0; w < `L1_WAYS; w++) begin
            if (state_q[idx][w] != INVALID && tag_q[idx][w] == tag) begin
                hit = 1'b1;
                way = `L1_WAY_WID'(w);
                st  = state_q[idx][w];
            end
        end
    endfunction

    always_comb begin
        lookup(proc_index, proc_tag, proc_hit, proc_way, proc_state);
        lookup(snoop_index, snoop_tag, snoop_hit, snoop_way, snoop_state);
    end

    // lowest free way wins, else the round-robin pointer
    always_comb begin
        victim_way = rr_q[proc_index];
        for (int w = `L1_WAYS - 1; w >= 0; w--) begin
            if (state_q[proc_index][w] == INVALID) begin
                victim_way = `L1_WAY_WID'(w);
            end
        end
    end

    assign victim_state = state_q[proc_index][victim_way];
    assign victim_tag   = tag_q[proc_index][victim_way];

    always_comb begin
        wr_set_full = 1'b1;
        for (int w = 0; w < `L1_WAYS; w++) begin
            if (state_q[proc_wr.index][w] == INVALID) begin
                wr_set_full = 1'b0;
            end
        end
    end

    // new tag in a full set means a replacement fill
    assign wr_new_tag = tag_q[proc_wr.index][proc_wr.way] != proc_wr.tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `L1_SETS; s++) begin
                rr_q[s] <= '0;
                for (int w = 0; w < `L1_WAYS; w++) begin
                    state_q[s][w] <= INVALID;
                end
            end
        end else begin
            if (proc_wr.en) begin
                state_q[proc_wr.index][proc_wr.way] <= proc_wr.state;
                if (wr_set_full && wr_new_tag) begin
                    rr_q[proc_wr.index] <= rr_q[proc_wr.index] + `L1_WAY_WID'(1);
                end
            end
            if (snoop_wr.en) begin
                state_q[snoop_wr.index][snoop_wr.way] <= snoop_wr.state;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (proc_wr.en) begin
            tag_q[proc_wr.index][proc_wr.way] <= proc_wr.tag;
        end
    end

endmodule

`default_nettype wire

/* l1_data_store.sv */
//==========================================================
// L1 data store, one word per way per set
// proc read/write port and snoop read port
//==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "l1_consts.svh"

module l1_data_store (
    input  wire                     clk,
    input  wire [`L1_INDEX_WID-1:0] proc_index,
    input  wire [`L1_WAY_WID-1:0]   proc_way,
    input  wire                     wr_en,
    input  wire [`L1_DATA_WID-1:0]  wdata,
    output logic [`L1_DATA_WID-1:0] proc_rdata,
    input  wire [`L1_INDEX_WID-1:0] snoop_index,
    input  wire [`L1_WAY_WID-1:0]   snoop_way,
    output logic [`L1_DATA_WID-1:0] snoop_rdata
);

    logic [`L1_DATA_WID-1:0] mem_q [`L1_SETS][`L1_WAYS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[proc_index][proc_way] <= wdata;
        end
    end

    // both reads are combinational
    assign proc_rdata  = mem_q[proc_index][proc_way];
    assign snoop_rdata = mem_q[snoop_index][snoop_way];

endmodule

`default_nettype wire

/* l1_proc_ctrl.sv */
//==========================================================
// L1 proc side controller
// CPU reads and writes: hit, upgrade, write-back and fill
//==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "l1_consts.svh"

module l1_proc_ctrl
    import mesi_pkg::*, l1_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire cpu_req_t             cpu_req,
    output cpu_rsp_t                  cpu_rsp,
    output mem_req_t                  mem_req,
    input  wire mem_rsp_t             mem_rsp,
    output logic [`L1_INDEX_WID-1:0]  index,
    output logic [`L1_TAG_WID-1:0]    tag,
    input  wire                       hit,
    input  wire [`L1_WAY_WID-1:0]     hit_way,
    input  wire mesi_e                hit_state,
    input  wire [`L1_WAY_WID-1:0]     victim_way,
    input  wire mesi_e                victim_state,
    input  wire [`L1_TAG_WID-1:0]     victim_tag,
    input  wire [`L1_DATA_WID-1:0]    rdata,
    output tag_wr_t                   tag_wr,
    output logic                      data_wr_en,
    output logic [`L1_DATA_WID-1:0]   data_wdata,
    output logic                      proc_busy
);

    proc_state_e             state_q;
    proc_state_e             state_d;
    cpu_req_t                req_q;
    logic [`L1_WAY_WID-1:0]  way_q;
    logic [`L1_TAG_WID-1:0]  vtag_q;
    logic [`L1_WAY_WID-1:0]  sel_way;
    logic [`L1_ADDR_WID-1:0] line_addr;

    assign index     = req_q.addr[`L1_OFFSET_WID +: `L1_INDEX_WID];
    assign tag       = req_q.addr[`L1_ADDR_WID-1 -: `L1_TAG_WID];
    assign line_addr = {tag, index, {`L1_OFFSET_WID{1'b0}}};
    assign sel_way   = hit ? hit_way : victim_way;
    assign proc_busy = state_q != IDLE;
    assign cpu_rsp   = '{done: state_q == RESPOND, rdata: rdata};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request sampled while idle, line choice fixed in lookup
    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            req_q <= cpu_req;
        end
        if (state_q == LOOKUP) begin
            way_q  <= sel_way;
            vtag_q <= victim_tag;
        end
    end

    //==========================================================
    // next state, memory request and store writes
    //==========================================================
    always_comb begin
        state_d    = state_q;
        tag_wr     = '{en: 1'b0, index: index, way: way_q, tag: tag, state: MODIFIED};
        data_wr_en = 1'b0;
        data_wdata = req_q.wdata;
        mem_req    = '{op: MEM_NONE, addr: line_addr, wdata: rdata};
        case (state_q)
            IDLE: begin
                if (cpu_req.rd || cpu_req.wr) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                tag_wr.way = sel_way;
                if (hit) begin
                    if (req_q.rd) begin
                        state_d = RESPOND;
                    end else if (hit_state == SHARED) begin
                        state_d = UPGRADE;
                    end else begin
                        // E or M, write in place
                        tag_wr.en  = 1'b1;
                        data_wr_en = 1'b1;
                        state_d    = RESPOND;
                    end
                end else if (victim_state == MODIFIED) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = FILL;
                end
            end
            UPGRADE: begin
                mem_req.op = MEM_UPGRADE;
                if (mem_rsp.done) begin
                    tag_wr.en  = 1'b1;
                    data_wr_en = 1'b1;
                    state_d    = RESPOND;
                end
            end
            WRITEBACK: begin
                mem_req.op   = MEM_WRITE;
                mem_req.addr = {vtag_q, index, {`L1_OFFSET_WID{1'b0}}};
                if (mem_rsp.done) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                if (req_q.rd) begin
                    mem_req.op = MEM_READ;
                end else begin
                    mem_req.op = MEM_READ_X;
                end
                if (mem_rsp.done) begin
                    tag_wr.en  = 1'b1;
                    data_wr_en = 1'b1;
                    if (req_q.rd) begin
                        data_wdata = mem_rsp.rdata;
                        if (mem_rsp.shared) begin
                            tag_wr.state = SHARED;
                        end else begin
                            tag_wr.state = EXCLUSIVE;
                        end
                    end
                    state_d = RESPOND;
                end
            end
            RESPOND: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* l1_snoop_ctrl.sv */
//==========================================================
// L1 snoop side controller
// line state updates and supply of modified data
//==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "l1_consts.svh"

module l1_snoop_ctrl
    import mesi_pkg::*, l1_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire snoop_op_e            snoop_op,
    input  wire [`L1_ADDR_WID-1:0]    snoop_addr,
    input  wire                       proc_busy,
    output logic [`L1_INDEX_WID-1:0]  index,
    output logic [`L1_TAG_WID-1:0]    tag,
    input  wire                       hit,
    input  wire [`L1_WAY_WID-1:0]     hit_way,
    input  wire mesi_e                hit_state,
    input  wire [`L1_DATA_WID-1:0]    rdata,
    output state_wr_t                 state_wr,
    output logic                      snoop_done,
    output logic                      snoop_hit,
    output logic                      snoop_data_valid,
    output logic [`L1_DATA_WID-1:0]   snoop_data
);

    logic go;
    logic supply;

    assign index = snoop_addr[`L1_OFFSET_WID +: `L1_INDEX_WID];
    assign tag   = snoop_addr[`L1_ADDR_WID-1 -: `L1_TAG_WID];

    // once per held op, only while proc side idles
    assign go     = snoop_op != SNP_NONE && !proc_busy && !snoop_done;
    assign supply = hit && hit_state == MODIFIED &&
                    (snoop_op == SNP_READ || snoop_op == SNP_READ_X);

    always_comb begin
        state_wr = '{en: go && hit, index: index, way: hit_way, state: INVALID};
        if (snoop_op == SNP_READ) begin
            state_wr.state = SHARED;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            snoop_done       <= 1'b0;
            snoop_hit        <= 1'b0;
            snoop_data_valid <= 1'b0;
        end else begin
            snoop_done       <= go;
            snoop_hit        <= go && hit;
            snoop_data_valid <= go && supply;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            snoop_data <= rdata;
        end
    end

endmodule

`default_nettype wire

/* l1_dcache.sv */
//==========================================================
// L1 data cache top, MESI coherent
// tag store, data store, proc and snoop controllers
//==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "l1_consts.svh"

module l1_dcache
    import mesi_pkg::*, l1_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire cpu_req_t             cpu_req,
    output cpu_rsp_t                  cpu_rsp,
    output mem_req_t                  mem_req,
    input  wire mem_rsp_t             mem_rsp,
    input  wire snoop_op_e            snoop_op,
    input  wire [`L1_ADDR_WID-1:0]    snoop_addr,
    output logic                      snoop_done,
    output logic                      snoop_hit,
    output logic                      snoop_data_valid,
    output logic [`L1_DATA_WID-1:0]   snoop_data
);

    //==========================================================
    // proc side lookup
    //==========================================================
    logic [`L1_INDEX_WID-1:0] proc_index;
    logic [`L1_TAG_WID-1:0]   proc_tag;
    logic                     proc_hit;
    logic [`L1_WAY_WID-1:0]   proc_way;
    mesi_e                    proc_state;
    logic [`L1_WAY_WID-1:0]   victim_way;
    mesi_e                    victim_state;
    logic [`L1_TAG_WID-1:0]   victim_tag;
    logic [`L1_DATA_WID-1:0]  proc_rdata;
    tag_wr_t                  proc_tag_wr;
    logic                     data_wr_en;
    logic [`L1_DATA_WID-1:0]  data_wdata;
    logic                     proc_busy;

    //==========================================================
    // snoop side lookup
    //==========================================================
    logic [`L1_INDEX_WID-1:0] snp_index;
    logic [`L1_TAG_WID-1:0]   snp_tag;
    logic                     snp_lookup_hit;
    logic [`L1_WAY_WID-1:0]   snp_way;
    mesi_e                    snp_state;
    logic [`L1_DATA_WID-1:0]  snp_rdata;
    state_wr_t                snp_state_wr;

    l1_tag_store u_tag_store (
        .clk          (clk),
        .rst          (rst),
        .proc_index   (proc_index),
        .proc_tag     (proc_tag),
        .proc_hit     (proc_hit),
        .proc_way     (proc_way),
        .proc_state   (proc_state),
        .victim_way   (victim_way),
        .victim_state (victim_state),
        .victim_tag   (victim_tag),
        .snoop_index  (snp_index),
        .snoop_tag    (snp_tag),
        .snoop_hit    (snp_lookup_hit),
        .snoop_way    (snp_way),
        .snoop_state  (snp_state),
        .proc_wr      (proc_tag_wr),
        .snoop_wr     (snp_state_wr)
    );

    // proc port follows the way the controller is working on
    l1_data_store u_data_store (
        .clk         (clk),
        .proc_index  (proc_index),
        .proc_way    (proc_tag_wr.way),
        .wr_en       (data_wr_en),
        .wdata       (data_wdata),
        .proc_rdata  (proc_rdata),
        .snoop_index (snp_index),
        .snoop_way   (snp_way),
        .snoop_rdata (snp_rdata)
    );

    l1_proc_ctrl u_proc_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .cpu_rsp      (cpu_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .index        (proc_index),
        .tag          (proc_tag),
        .hit          (proc_hit),
        .hit_way      (proc_way),
        .hit_state    (proc_state),
        .victim_way   (victim_way),
        .victim_state (victim_state),
        .victim_tag   (victim_tag),
        .rdata        (proc_rdata),
        .tag_wr       (proc_tag_wr),
        .data_wr_en   (data_wr_en),
        .data_wdata   (data_wdata),
        .proc_busy    (proc_busy)
    );

    l1_snoop_ctrl u_snoop_ctrl (
        .clk              (clk),
        .rst              (rst),
        .snoop_op         (snoop_op),
        .snoop_addr       (snoop_addr),
        .proc_busy        (proc_busy),
        .index            (snp_index),
        .tag              (snp_tag),
        .hit              (snp_lookup_hit),
        .hit_way          (snp_way),
        .hit_state        (snp_state),
        .rdata            (snp_rdata),
        .state_wr         (snp_state_wr),
        .snoop_done       (snoop_done),
        .snoop_hit        (snoop_hit),
        .snoop_data_valid (snoop_data_valid),
        .snoop_data       (snoop_data)
    );

endmodule

`default_nettype wire

/* tb_l1_dcache.sv */
//==========================================================
// L1 data cache testbench
// directed tests against a fixed-latency lower-level memory
//==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "l1_consts.svh"

module tb_l1_dcache
    import mesi_pkg::*, l1_pkg::*;
();

    localparam int TIMEOUT = 200;
    localparam int MEM_LAT = 3;

    logic                    clk;
    logic                    rst;
    cpu_req_t                cpu_req;
    cpu_rsp_t                cpu_rsp;
    mem_req_t                mem_req;
    mem_rsp_t                mem_rsp;
    snoop_op_e               snoop_op;
    logic [`L1_ADDR_WID-1:0] snoop_addr;
    logic                    snoop_done;
    logic                    snoop_hit;
    logic                    snoop_data_valid;
    logic [`L1_DATA_WID-1:0] snoop_data;

    logic [`L1_DATA_WID-1:0] mem_model [logic [`L1_ADDR_WID-1:0]];
    mem_req_t                req_log [$];
    logic                    mem_shared;
    integer                  seed;
    int                      errors;
    int                      timeouts;

    l1_dcache uut (
        .clk              (clk),
        .rst              (rst),
        .cpu_req          (cpu_req),
        .cpu_rsp          (cpu_rsp),
        .mem_req          (mem_req),
        .mem_rsp          (mem_rsp),
        .snoop_op         (snoop_op),
        .snoop_addr       (snoop_addr),
        .snoop_done       (snoop_done),
        .snoop_hit        (snoop_hit),
        .snoop_data_valid (snoop_data_valid),
        .snoop_data       (snoop_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //==========================================================
    // lower-level memory model
    //==========================================================
    initial begin
        mem_rsp = '0;
        seed    = 40;
        forever begin
            @(negedge clk);
            if (!rst && mem_req.op != MEM_NONE) begin
                req_log.push_back(mem_req);
                repeat (MEM_LAT) @(posedge clk);
                #1;
                if (mem_req.op == MEM_WRITE) begin
                    mem_model[mem_req.addr] = mem_req.wdata;
                end else if (!mem_model.exists(mem_req.addr)) begin
                    mem_model[mem_req.addr] = $random(seed);
                end
                mem_rsp.rdata  = mem_model[mem_req.addr];
                mem_rsp.shared = mem_shared;
                mem_rsp.done   = 1'b1;
                @(posedge clk);
                #1;
                mem_rsp.done = 1'b0;
            end
        end
    end

    function automatic logic [`L1_ADDR_WID-1:0] line_addr(
        input logic [`L1_TAG_WID-1:0]   t,
        input logic [`L1_INDEX_WID-1:0] i
    );
        return {t, i, {`L1_OFFSET_WID{1'b0}}};
    endfunction

    task automatic check(input bit ok, input string what);
        assert (ok) else begin
            errors++;
            $display("FAIL %0t: %s", $time, what);
        end
    endtask

    // one CPU request held until done with edges counted from the drive
    task automatic cpu_access(
        input  logic                    is_wr,
        input  logic [`L1_ADDR_WID-1:0] addr,
        input  logic [`L1_DATA_WID-1:0] wdata,
        output logic [`L1_DATA_WID-1:0] rdata,
        output int                      edges
    );
        logic seen;
        seen  = 1'b0;
        edges = 0;
        @(posedge clk);
        #1;
        cpu_req = '{rd: !is_wr, wr: is_wr, addr: addr, wdata: wdata};
        while (!seen && edges < TIMEOUT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            seen = cpu_rsp.done;
        end
        rdata = cpu_rsp.rdata;
        if (!seen) begin
            timeouts++;
            $display("timeout: no CPU response for address %h", addr);
        end
        @(posedge clk);
        #1;
        cpu_req = '0;
    endtask

    task automatic run_snoop(
        input  snoop_op_e               op,
        input  logic [`L1_ADDR_WID-1:0] addr,
        output logic                    hit,
        output logic                    valid,
        output logic [`L1_DATA_WID-1:0] data
    );
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        @(posedge clk);
        #1;
        snoop_op   = op;
        snoop_addr = addr;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = snoop_done;
        end
        hit   = snoop_hit;
        valid = snoop_data_valid;
        data  = snoop_data;
        if (!seen) begin
            timeouts++;
            $display("timeout: no snoop response for address %h", addr);
        end
        @(posedge clk);
        #1;
        snoop_op = SNP_NONE;
    endtask

    //==========================================================
    // directed tests
    //==========================================================
    task automatic reset_read_hit();
        logic [`L1_ADDR_WID-1:0] a;
        logic [`L1_DATA_WID-1:0] first;
        logic [`L1_DATA_WID-1:0] again;
        int                      edges;
        int                      base;
        a = line_addr(26'h5, 4'h3);
        @(negedge clk);
        check(!cpu_rsp.done && !snoop_done && mem_req.op == MEM_NONE,
              "outputs active after reset");
        base = req_log.size();
        cpu_access(1'b0, a, '0, first, edges);
        check(req_log.size() == base + 1 && req_log[base].op == MEM_READ &&
              req_log[base].addr == a, "read miss did not issue one MEM_READ");
        check(first == mem_model[a],
              $sformatf("read miss got %h, memory holds %h", first, mem_model[a]));
        base = req_log.size();
        cpu_access(1'b0, a, '0, again, edges);
        check(req_log.size() == base, "read hit went to memory");
        check(again == first && edges == 2,
              $sformatf("read hit got %h after %0d edges", again, edges));
    endtask

    task automatic write_hit_snoop_supply();
        logic [`L1_ADDR_WID-1:0] b;
        logic [`L1_ADDR_WID-1:0] d;
        logic [`L1_DATA_WID-1:0] rd;
        logic [`L1_DATA_WID-1:0] data;
        logic                    hit;
        logic                    valid;
        int                      edges;
        int                      base;
        b          = line_addr(26'h11, 4'h5);
        d          = line_addr(26'h24, 4'hb);
        mem_shared = 1'b0;
        base       = req_log.size();
        cpu_access(1'b0, b, '0, rd, edges);
        check(req_log.size() == base + 1 && req_log[base].op == MEM_READ,
              "read miss did not fill");
        base = req_log.size();
        cpu_access(1'b1, b, 32'ha5a5_0001, rd, edges);
        check(req_log.size() == base && edges == 2, "write hit on exclusive line not local");
        run_snoop(SNP_READ, b, hit, valid, data);
        check(hit && valid && data == 32'ha5a5_0001,
              $sformatf("snoop read hit %b valid %b data %h", hit, valid, data));
        base = req_log.size();
        cpu_access(1'b1, b, 32'ha5a5_0002, rd, edges);
        check(req_log.size() == base + 1 && req_log[base].op == MEM_UPGRADE &&
              req_log[base].addr == b, "write to shared line did not upgrade");
        base = req_log.size();
        cpu_access(1'b0, b, '0, rd, edges);
        check(req_log.size() == base && rd == 32'ha5a5_0002,
              $sformatf("read after upgrade got %h", rd));
        // fill answered as shared installs SHARED
        mem_shared = 1'b1;
        cpu_access(1'b0, d, '0, rd, edges);
        mem_shared = 1'b0;
        base = req_log.size();
        cpu_access(1'b1, d, 32'ha5a5_0003, rd, edges);
        check(req_log.size() == base + 1 && req_log[base].op == MEM_UPGRADE &&
              req_log[base].addr == d, "write to line filled as shared did not upgrade");
    endtask

    task automatic write_miss_fill();
        logic [`L1_ADDR_WID-1:0] c;
        logic [`L1_DATA_WID-1:0] rd;
        int                      edges;
        int                      base;
        c    = line_addr(26'h22, 4'h7);
        base = req_log.size();
        cpu_access(1'b1, c, 32'h5eed_0003, rd, edges);
        check(req_log.size() == base + 1 && req_log[base].op == MEM_READ_X &&
              req_log[base].addr == c, "write miss did not issue MEM_READ_X");
        base = req_log.size();
        cpu_access(1'b0, c, '0, rd, edges);
        check(req_log.size() == base && rd == 32'h5eed_0003,
              $sformatf("read after write miss got %h", rd));
    endtask

    // same index with the pointer still at way 0 when the set first fills
    task automatic modified_eviction();
        logic [`L1_ADDR_WID-1:0] t1;
        logic [`L1_ADDR_WID-1:0] t2;
        logic [`L1_ADDR_WID-1:0] t3;
        logic [`L1_DATA_WID-1:0] rd;
        int                      edges;
        int                      base;
        t1 = line_addr(26'h31, 4'h9);
        t2 = line_addr(26'h32, 4'h9);
        t3 = line_addr(26'h33, 4'h9);
        cpu_access(1'b0, t1, '0, rd, edges);
        cpu_access(1'b0, t2, '0, rd, edges);
        cpu_access(1'b1, t1, 32'hdead_0004, rd, edges);
        base = req_log.size();
        cpu_access(1'b0, t3, '0, rd, edges);
        check(req_log.size() == base + 2 && req_log[base].op == MEM_WRITE &&
              req_log[base].addr == t1 && req_log[base].wdata == 32'hdead_0004,
              "eviction did not write back the modified line first");
        check(req_log[base + 1].op == MEM_READ && req_log[base + 1].addr == t3,
              "eviction did not fill the new line");
        check(mem_model[t1] == 32'hdead_0004 && rd == mem_model[t3],
              $sformatf("memory holds %h, fill read %h", mem_model[t1], rd));
        base = req_log.size();
        cpu_access(1'b0, t2, '0, rd, edges);
        check(req_log.size() == base, "way 1 was evicted instead of way 0");
    endtask

    task automatic snoop_invalidate_miss();
        logic [`L1_ADDR_WID-1:0] a;
        logic [`L1_DATA_WID-1:0] rd;
        logic [`L1_DATA_WID-1:0] data;
        logic                    hit;
        logic                    valid;
        int                      edges;
        int                      base;
        a = line_addr(26'h5, 4'h3);
        run_snoop(SNP_INV, a, hit, valid, data);
        check(hit && !valid, $sformatf("snoop invalidate hit %b valid %b", hit, valid));
        base = req_log.size();
        cpu_access(1'b0, a, '0, rd, edges);
        check(req_log.size() == base + 1 && req_log[base].op == MEM_READ &&
              rd == mem_model[a], "read after invalidate did not refetch");
        run_snoop(SNP_READ, line_addr(26'h3ff, 4'hc), hit, valid, data);
        check(!hit && !valid, $sformatf("snoop miss hit %b valid %b", hit, valid));
    endtask

    initial begin
        rst        = 1'b1;
        cpu_req    = '0;
        snoop_op   = SNP_NONE;
        snoop_addr = '0;
        mem_shared = 1'b0;
        errors     = 0;
        timeouts   = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_read_hit();
        write_hit_snoop_supply();
        write_miss_fill();
        modified_eviction();
        snoop_invalidate_miss();
        $display("check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
mesi_pkg.sv
l1_pkg.sv
l1_tag_store.sv
l1_data_store.sv
l1_proc_ctrl.sv
l1_snoop_ctrl.sv
l1_dcache.sv
tb_l1_dcache.sv

/* run_sim.sh */
#!/bin/sh
# build and run the L1 data cache testbench with Verilator
verilator --binary --timing --assert -f project.f --top-module tb_l1_dcache \
    && ./obj_dir/Vtb_l1_dcache > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
# the log decides the result
grep -q '>>> FAIL' sim.log && exit 1 || exit 0
